// ==== compile.f ====
+incdir+verif
design/ooo_exec_pkg.sv
design/arith_unit.sv
design/branch_resolve.sv
design/exec_commit_latch.sv
design/ooo_execute_stage.sv
verif/tb_ooo_execute_stage.sv

// ==== design/arith_unit.sv ====
`timescale 1ns/1ps
`default_nettype none

module arith_unit
  import ooo_exec_pkg::*;
(
  input  instr_class_e instr_class,
  input  exec_op_u     op,
  input  word_t        port_a,
  input  word_t        port_b,
  input  word_t        pc,
  input  reg_idx_t     reg_rd,
  output logic         wen,
  output word_t        wdata,
  output reg_idx_t     rd_out
);

  logic [4:0] shamt;
  logic       lt_signed;
  logic       lt_unsigned;
  word_t      alu_res;
  word_t      link_addr;
  logic       writes_rd;

  // Shift amount from the low bits of operand B only
  assign shamt       = port_b[4:0];
  assign lt_signed   = $signed(port_a) < $signed(port_b);
  assign lt_unsigned = port_a < port_b;
  assign link_addr   = pc + INSTR_BYTES;

  always_comb begin
    case (op.alu)
      ADD:     alu_res = port_a + port_b;
      SUB:     alu_res = port_a - port_b;
      AND:     alu_res = port_a & port_b;
      OR:      alu_res = port_a | port_b;
      XOR:     alu_res = port_a ^ port_b;
      SLT:     alu_res = {{(WORD_W-1){1'b0}}, lt_signed};
      SLTU:    alu_res = {{(WORD_W-1){1'b0}}, lt_unsigned};
      SLL:     alu_res = port_a << shamt;
      SRL:     alu_res = port_a >> shamt;
      SRA:     alu_res = word_t'($signed(port_a) >>> shamt);
      default: alu_res = '0;
    endcase
  end

  // Result select by instruction class
  always_comb begin
    case (instr_class)
      ALU:       wdata = alu_res;
      JAL, JALR: wdata = link_addr;
      default:   wdata = '0;
    endcase
  end

  // Branches never write; x0 writes are dropped here
  assign writes_rd = (instr_class == ALU) || (instr_class == JAL) ||
                     (instr_class == JALR);
  assign wen       = writes_rd && (reg_rd != '0);
  assign rd_out    = reg_rd;

endmodule

`default_nettype wire

// ==== design/branch_resolve.sv ====
`timescale 1ns/1ps
`default_nettype none

module branch_resolve
  import ooo_exec_pkg::*;
(
  input  logic         valid,
  input  instr_class_e instr_class,
  input  exec_op_u     op,
  input  word_t        port_a,
  input  word_t        port_b,
  input  word_t        imm,
  input  word_t        pc,
  input  logic         prediction,
  output logic         branch_taken,
  output word_t        resolved_addr,
  output word_t        jump_addr,
  output logic         mispredict,
  output word_t        brj_addr
);

  logic  branch_instr;
  logic  jump_instr;
  logic  cond_true;
  logic  br_mispredict;
  word_t pc4;
  word_t branch_addr;
  word_t jalr_target;

  assign branch_instr = (instr_class == BRANCH);
  assign jump_instr   = (instr_class == JAL) || (instr_class == JALR);

  always_comb begin
    case (op.br)
      BEQ:     cond_true = (port_a == port_b);
      BNE:     cond_true = (port_a != port_b);
      BLT:     cond_true = $signed(port_a) < $signed(port_b);
      BGE:     cond_true = $signed(port_a) >= $signed(port_b);
      BLTU:    cond_true = port_a < port_b;
      BGEU:    cond_true = port_a >= port_b;
      default: cond_true = 1'b0;
    endcase
  end

  assign branch_taken = branch_instr && cond_true;

  // Target addresses
  assign pc4           = pc + INSTR_BYTES;
  assign branch_addr   = pc + imm;
  assign resolved_addr = branch_taken ? branch_addr : pc4;
  // JALR target is register relative, low bit forced clear
  assign jalr_target   = (port_a + imm) & ~word_t'(1);
  assign jump_addr     = (instr_class == JALR) ? jalr_target : branch_addr;

  // Redirect to the hazard unit; jumps always redirect
  assign br_mispredict = branch_instr && (prediction != branch_taken);
  assign mispredict    = valid && (jump_instr || br_mispredict);

  always_comb begin
    if (!valid) begin
      brj_addr = '0;
    end else if (jump_instr) begin
      brj_addr = jump_addr;
    end else if (br_mispredict) begin
      brj_addr = resolved_addr;
    end else begin
      brj_addr = pc4;
    end
  end

endmodule

`default_nettype wire

// ==== design/exec_commit_latch.sv ====
`timescale 1ns/1ps
`default_nettype none

module exec_commit_latch
  import ooo_exec_pkg::*;
(
  input  logic         CLK,
  input  logic         nRST,
  input  logic         stall_commit,
  input  logic         flush,
  input  logic         valid,
  input  instr_class_e instr_class,
  input  logic         alu_wen,
  input  word_t        alu_wdata,
  input  reg_idx_t     alu_rd,
  input  cb_index_t    index,
  input  word_t        pc,
  input  logic         prediction,
  input  logic         branch_taken,
  input  word_t        resolved_addr,
  input  word_t        jump_addr,
  output logic         done,
  output logic         wen,
  output word_t        wdata,
  output reg_idx_t     reg_rd_out,
  output cb_index_t    index_out,
  output word_t        pc_out,
  output logic         branch_instr,
  output logic         jump_instr,
  output logic         branch_taken_out,
  output logic         prediction_out,
  output word_t        br_resolved_addr,
  output word_t        jump_addr_out
);

  logic clear_rec;

  // Flush wins over stall; an idle load also writes a zero record
  assign clear_rec = flush || (!stall_commit && !valid);

  always_ff @(posedge CLK or negedge nRST) begin
    if (!nRST) begin
      done             <= 1'b0;
      wen              <= 1'b0;
      wdata            <= '0;
      reg_rd_out       <= '0;
      index_out        <= '0;
      pc_out           <= '0;
      branch_instr     <= 1'b0;
      jump_instr       <= 1'b0;
      branch_taken_out <= 1'b0;
      prediction_out   <= 1'b0;
      br_resolved_addr <= '0;
      jump_addr_out    <= '0;
    end else if (clear_rec) begin
      done             <= 1'b0;
      wen              <= 1'b0;
      wdata            <= '0;
      reg_rd_out       <= '0;
      index_out        <= '0;
      pc_out           <= '0;
      branch_instr     <= 1'b0;
      jump_instr       <= 1'b0;
      branch_taken_out <= 1'b0;
      prediction_out   <= 1'b0;
      br_resolved_addr <= '0;
      jump_addr_out    <= '0;
    end else if (!stall_commit) begin
      done             <= 1'b1;
      // Writeback from the arithmetic unit
      wen              <= alu_wen;
      wdata            <= alu_wdata;
      reg_rd_out       <= alu_rd;
      index_out        <= index;
      pc_out           <= pc;
      // Predictor update fields
      branch_instr     <= (instr_class == BRANCH);
      jump_instr       <= (instr_class == JAL) || (instr_class == JALR);
      branch_taken_out <= branch_taken;
      prediction_out   <= prediction;
      br_resolved_addr <= resolved_addr;
      jump_addr_out    <= jump_addr;
    end
  end

endmodule

`default_nettype wire

// ==== design/ooo_exec_pkg.sv ====
`default_nettype none

package ooo_exec_pkg;

  // Datapath widths
  localparam int WORD_W       = 32;
  localparam int REG_W        = 5;
  localparam int NUM_CB_ENTRY = 16;
  localparam int CB_IDX_W     = $clog2(NUM_CB_ENTRY);

  typedef logic [WORD_W-1:0]   word_t;
  typedef logic [REG_W-1:0]    reg_idx_t;
  typedef logic [CB_IDX_W-1:0] cb_index_t;

  // PC step to the next sequential instruction
  localparam word_t INSTR_BYTES = 32'd4;

  typedef enum logic [1:0] {
    ALU    = 2'd0,
    BRANCH = 2'd1,
    JAL    = 2'd2,
    JALR   = 2'd3
  } instr_class_e;

  typedef enum logic [3:0] {
    ADD  = 4'h0,
    SUB  = 4'h1,
    AND  = 4'h2,
    OR   = 4'h3,
    XOR  = 4'h4,
    SLT  = 4'h5,
    SLTU = 4'h6,
    SLL  = 4'h7,
    SRL  = 4'h8,
    SRA  = 4'h9
  } alu_op_e;

  typedef enum logic [3:0] {
    BEQ  = 4'h0,
    BNE  = 4'h1,
    BLT  = 4'h4,
    BGE  = 4'h5,
    BLTU = 4'h6,
    BGEU = 4'h7
  } br_cond_e;

  // Same op field, read as ALU op or branch condition depending on class
  typedef union packed {
    alu_op_e  alu;
    br_cond_e br;
  } exec_op_u;

endpackage

`default_nettype wire

// ==== design/ooo_execute_stage.sv ====
`timescale 1ns/1ps
`default_nettype none

module ooo_execute_stage
  import ooo_exec_pkg::*;
(
  input  logic         CLK,
  input  logic         nRST,
  // Issue side
  input  logic         valid,
  input  instr_class_e instr_class,
  input  exec_op_u     op,
  input  word_t        port_a,
  input  word_t        port_b,
  input  word_t        imm,
  input  word_t        pc,
  input  reg_idx_t     reg_rd,
  input  cb_index_t    index,
  input  logic         prediction,
  // Hazard unit
  input  logic         stall_commit,
  input  logic         flush,
  output logic         mispredict,
  output word_t        brj_addr,
  // Commit record
  output logic         done,
  output logic         wen,
  output word_t        wdata,
  output reg_idx_t     reg_rd_out,
  output cb_index_t    index_out,
  output word_t        pc_out,
  output logic         branch_instr,
  output logic         jump_instr,
  output logic         branch_taken_out,
  output logic         prediction_out,
  output word_t        br_resolved_addr,
  output word_t        jump_addr_out
);

  logic     alu_wen;
  word_t    alu_wdata;
  reg_idx_t alu_rd;
  logic     branch_taken;
  word_t    resolved_addr;
  word_t    jump_addr;

  arith_unit u_arith (
    .instr_class (instr_class),
    .op          (op),
    .port_a      (port_a),
    .port_b      (port_b),
    .pc          (pc),
    .reg_rd      (reg_rd),
    .wen         (alu_wen),
    .wdata       (alu_wdata),
    .rd_out      (alu_rd)
  );

  branch_resolve u_bres (
    .valid         (valid),
    .instr_class   (instr_class),
    .op            (op),
    .port_a        (port_a),
    .port_b        (port_b),
    .imm           (imm),
    .pc            (pc),
    .prediction    (prediction),
    .branch_taken  (branch_taken),
    .resolved_addr (resolved_addr),
    .jump_addr     (jump_addr),
    .mispredict    (mispredict),
    .brj_addr      (brj_addr)
  );

  exec_commit_latch u_latch (
    .CLK              (CLK),
    .nRST             (nRST),
    .stall_commit     (stall_commit),
    .flush            (flush),
    .valid            (valid),
    .instr_class      (instr_class),
    .alu_wen          (alu_wen),
    .alu_wdata        (alu_wdata),
    .alu_rd           (alu_rd),
    .index            (index),
    .pc               (pc),
    .prediction       (prediction),
    .branch_taken     (branch_taken),
    .resolved_addr    (resolved_addr),
    .jump_addr        (jump_addr),
    .done             (done),
    .wen              (wen),
    .wdata            (wdata),
    .reg_rd_out       (reg_rd_out),
    .index_out        (index_out),
    .pc_out           (pc_out),
    .branch_instr     (branch_instr),
    .jump_instr       (jump_instr),
    .branch_taken_out (branch_taken_out),
    .prediction_out   (prediction_out),
    .br_resolved_addr (br_resolved_addr),
    .jump_addr_out    (jump_addr_out)
  );

endmodule

`default_nettype wire

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the execute stage testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -f compile.f --top-module tb_ooo_execute_stage \
  -o sim_tb > build.log 2>&1
if [ $? -ne 0 ]; then
  cat build.log
  echo "Build failed"
  exit 1
fi

./obj_dir/sim_tb > sim.log 2>&1
if [ $? -ne 0 ]; then
  cat sim.log
  echo "Simulation did not run to completion"
  exit 1
fi
cat sim.log

# The log decides the result
if grep -qx "Verification passed" sim.log; then
  exit 0
fi
exit 1

// ==== verif/tb_checks.svh ====
// Error counters for the closing summary
int mismatch_count = 0;
int timeout_count  = 0;

task automatic check_word(input string name, input word_t exp, input word_t act);
  if (exp !== act) begin
    $display("Mismatch %s: expected %h, actual %h", name, exp, act);
    mismatch_count++;
  end
endtask

task automatic check_reg(input string name, input reg_idx_t exp, input reg_idx_t act);
  if (exp !== act) begin
    $display("Mismatch %s: expected %0d, actual %0d", name, exp, act);
    mismatch_count++;
  end
endtask

task automatic check_index(input string name, input cb_index_t exp, input cb_index_t act);
  if (exp !== act) begin
    $display("Mismatch %s: expected %0d, actual %0d", name, exp, act);
    mismatch_count++;
  end
endtask

task automatic check_bit(input string name, input logic exp, input logic act);
  if (exp !== act) begin
    $display("Mismatch %s: expected %b, actual %b", name, exp, act);
    mismatch_count++;
  end
endtask

task automatic report_timeout(input string what);
  $display("Timeout: %s did not complete within its cycle limit", what);
  timeout_count++;
endtask

// ==== verif/tb_ooo_execute_stage.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_ooo_execute_stage
  import ooo_exec_pkg::*;
();

  localparam int RESET_CYCLES = 10;
  localparam int RESET_LIMIT  = 4;
  // Commit record is due one edge after acceptance
  localparam int COMMIT_LIMIT = 1;
  localparam br_cond_e CONDS [6] = '{BEQ, BNE, BLT, BGE, BLTU, BGEU};
  // Equal, less, greater, then signed less but unsigned greater
  localparam word_t PAIR_A [4] = '{32'h0000_0010, 32'h0000_0005, 32'h0000_0020, 32'hffff_fff0};
  localparam word_t PAIR_B [4] = '{32'h0000_0010, 32'h0000_0009, 32'h0000_0003, 32'h0000_0004};

  logic         CLK = 1'b0;
  logic         nRST;
  logic         valid;
  instr_class_e instr_class;
  exec_op_u     op;
  word_t        port_a;
  word_t        port_b;
  word_t        imm;
  word_t        pc;
  reg_idx_t     reg_rd;
  cb_index_t    index;
  logic         prediction;
  logic         stall_commit;
  logic         flush;
  logic         mispredict;
  word_t        brj_addr;
  logic         done;
  logic         wen;
  word_t        wdata;
  reg_idx_t     reg_rd_out;
  cb_index_t    index_out;
  word_t        pc_out;
  logic         branch_instr;
  logic         jump_instr;
  logic         branch_taken_out;
  logic         prediction_out;
  word_t        br_resolved_addr;
  word_t        jump_addr_out;
  integer       seed = 32'h396e;

  ooo_execute_stage dut0 (.*);

  always #50 CLK = ~CLK;

  `include "tb_checks.svh"

  function automatic word_t alu_model(input alu_op_e f, input word_t a, input word_t b);
    case (f)
      ADD:     return a + b;
      SUB:     return a - b;
      AND:     return a & b;
      OR:      return a | b;
      XOR:     return a ^ b;
      SLT:     return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
      SLTU:    return (a < b) ? 32'd1 : 32'd0;
      SLL:     return a << b[4:0];
      SRL:     return a >> b[4:0];
      SRA:     return $signed(a) >>> b[4:0];
      default: return '0;
    endcase
  endfunction

  function automatic logic branch_model(input br_cond_e c, input word_t a, input word_t b);
    case (c)
      BEQ:     return a == b;
      BNE:     return a != b;
      BLT:     return $signed(a) < $signed(b);
      BGE:     return $signed(a) >= $signed(b);
      BLTU:    return a < b;
      BGEU:    return a >= b;
      default: return 1'b0;
    endcase
  endfunction

  // Tasks start and end 1 ns after a rising edge
  task automatic step();
    @(posedge CLK);
    #1;
  endtask

  task automatic issue(input instr_class_e cls, input exec_op_u o, input word_t a,
                       input word_t b, input word_t im, input word_t p, input reg_idx_t rd,
                       input cb_index_t idx, input logic pred);
    valid       = 1'b1;
    instr_class = cls;
    op          = o;
    port_a      = a;
    port_b      = b;
    imm         = im;
    pc          = p;
    reg_rd      = rd;
    index       = idx;
    prediction  = pred;
  endtask

  task automatic wait_commit(input string what);
    int cycles;
    cycles = 0;
    do begin
      step();
      cycles++;
    end while (!done && cycles < COMMIT_LIMIT);
    if (!done) report_timeout({what, " commit"});
  endtask

  task automatic apply_reset();
    int cycles;
    nRST   = 1'b0;
    cycles = 0;
    while (cycles < RESET_CYCLES) begin
      @(posedge CLK);
      cycles++;
    end
    #1;
    nRST   = 1'b1;
    cycles = 0;
    do begin
      step();
      cycles++;
    end while (done !== 1'b0 && cycles < RESET_LIMIT);
    if (done !== 1'b0) report_timeout("reset release");
  endtask

  task automatic check_zero_record(input string name);
    check_bit({name, " done"}, 1'b0, done);
    check_bit({name, " wen"}, 1'b0, wen);
    check_word({name, " wdata"}, '0, wdata);
    check_reg({name, " reg_rd_out"}, '0, reg_rd_out);
    check_index({name, " index_out"}, '0, index_out);
    check_word({name, " pc_out"}, '0, pc_out);
    check_bit({name, " branch_instr"}, 1'b0, branch_instr);
    check_bit({name, " jump_instr"}, 1'b0, jump_instr);
    check_bit({name, " branch_taken_out"}, 1'b0, branch_taken_out);
    check_bit({name, " prediction_out"}, 1'b0, prediction_out);
    check_word({name, " br_resolved_addr"}, '0, br_resolved_addr);
    check_word({name, " jump_addr_out"}, '0, jump_addr_out);
  endtask

  task automatic reset_and_idle();
    exec_op_u o;
    o.alu = ADD;
    check_zero_record("reset");
    check_bit("reset mispredict", 1'b0, mispredict);
    check_word("reset brj_addr", '0, brj_addr);
    issue(ALU, o, 32'h11, 32'h22, '0, 32'h0f00, 5'd2, 4'd1, 1'b0);
    wait_commit("idle setup");
    // Jump left on the bus with valid low must not redirect
    issue(JAL, o, 32'h11, 32'h22, 32'h41, 32'h1000, 5'd9, 4'd3, 1'b1);
    valid = 1'b0;
    #1;
    check_bit("idle mispredict", 1'b0, mispredict);
    check_word("idle brj_addr", '0, brj_addr);
    step();
    check_zero_record("idle");
  endtask

  task automatic alu_ops();
    exec_op_u o;
    alu_op_e  f;
    word_t    a;
    word_t    b;
    reg_idx_t rd;
    for (int i = 0; i < 10; i++) begin
      f     = alu_op_e'(i);
      o.alu = f;
      a     = $random(seed);
      b     = $random(seed);
      if (f == SRA) a[31] = 1'b1;
      // OR goes to x0 so its write must be dropped
      rd = (f == OR) ? '0 : reg_idx_t'(i + 1);
      issue(ALU, o, a, b, '0, 32'h100 + i * 4, rd, cb_index_t'(i), 1'b0);
      wait_commit(f.name());
      check_word({f.name(), " wdata"}, alu_model(f, a, b), wdata);
      check_reg({f.name(), " reg_rd_out"}, rd, reg_rd_out);
      check_index({f.name(), " index_out"}, cb_index_t'(i), index_out);
      check_bit({f.name(), " wen"}, rd != '0, wen);
    end
  endtask

  task automatic cond_branches();
    exec_op_u o;
    br_cond_e cond;
    string    tname;
    word_t    p;
    word_t    im;
    logic     taken;
    logic     pred;
    logic     exp_mis;
    im = 32'h0000_0080;
    for (int c = 0; c < 6; c++) begin
      for (int j = 0; j < 4; j++) begin
        for (int q = 0; q < 2; q++) begin
          cond    = CONDS[c];
          o.br    = cond;
          pred    = q[0];
          p       = 32'h2000 + (c * 8 + j * 2 + q) * 4;
          taken   = branch_model(cond, PAIR_A[j], PAIR_B[j]);
          exp_mis = (pred != taken);
          tname   = $sformatf("%s pair%0d pred%0b", cond.name(), j, pred);
          issue(BRANCH, o, PAIR_A[j], PAIR_B[j], im, p, 5'd7, cb_index_t'(j), pred);
          #1;
          check_bit({tname, " mispredict"}, exp_mis, mispredict);
          check_word({tname, " brj_addr"}, (exp_mis && taken) ? p + im : p + 32'd4, brj_addr);
          wait_commit(tname);
          check_bit({tname, " branch_taken_out"}, taken, branch_taken_out);
          check_word({tname, " br_resolved_addr"}, taken ? p + im : p + 32'd4,
                     br_resolved_addr);
          check_bit({tname, " prediction_out"}, pred, prediction_out);
          check_bit({tname, " wen"}, 1'b0, wen);
          check_bit({tname, " branch_instr"}, 1'b1, branch_instr);
        end
      end
    end
  endtask

  task automatic one_jump(input instr_class_e cls, input word_t a, input word_t im,
                          input word_t p);
    exec_op_u o;
    word_t    target;
    o.alu  = ADD;
    // JAL is pc relative, JALR register relative with bit 0 dropped
    target = (cls == JAL) ? p + im : (a + im) & 32'hffff_fffe;
    issue(cls, o, a, 32'h0, im, p, 5'd1, 4'd9, 1'b0);
    #1;
    check_bit({cls.name(), " mispredict"}, 1'b1, mispredict);
    check_word({cls.name(), " brj_addr"}, target, brj_addr);
    wait_commit(cls.name());
    check_word({cls.name(), " wdata"}, p + 32'd4, wdata);
    check_bit({cls.name(), " wen"}, 1'b1, wen);
    check_bit({cls.name(), " jump_instr"}, 1'b1, jump_instr);
    check_word({cls.name(), " jump_addr_out"}, target, jump_addr_out);
  endtask

  task automatic jumps();
    one_jump(JAL, $random(seed), 32'h0000_0125, 32'h0000_3000);
    one_jump(JALR, 32'h0000_4002, 32'h0000_0013, 32'h0000_3100);
  endtask

  task automatic stall_and_flush();
    exec_op_u o;
    o.alu = ADD;
    issue(ALU, o, 32'd100, 32'd23, '0, 32'h5000, 5'd3, 4'd4, 1'b0);
    wait_commit("stall first");
    o.alu = SUB;
    issue(ALU, o, 32'd100, 32'd23, '0, 32'h5004, 5'd5, 4'd6, 1'b0);
    stall_commit = 1'b1;
    step();
    check_word("stall wdata", 32'd123, wdata);
    check_reg("stall reg_rd_out", 5'd3, reg_rd_out);
    check_index("stall index_out", 4'd4, index_out);
    check_word("stall pc_out", 32'h5000, pc_out);
    check_bit("stall done", 1'b1, done);
    stall_commit = 1'b0;
    wait_commit("stall release");
    check_word("release wdata", 32'd77, wdata);
    check_reg("release reg_rd_out", 5'd5, reg_rd_out);
    check_index("release index_out", 4'd6, index_out);
    check_word("release pc_out", 32'h5004, pc_out);
    flush = 1'b1;
    step();
    check_zero_record("flush");
    flush = 1'b0;
    wait_commit("reload");
    stall_commit = 1'b1;
    flush        = 1'b1;
    step();
    check_zero_record("flush over stall");
    stall_commit = 1'b0;
    flush        = 1'b0;
    valid        = 1'b0;
  endtask

  initial begin
    nRST         = 1'b0;
    valid        = 1'b0;
    instr_class  = ALU;
    op           = '0;
    port_a       = '0;
    port_b       = '0;
    imm          = '0;
    pc           = '0;
    reg_rd       = '0;
    index        = '0;
    prediction   = 1'b0;
    stall_commit = 1'b0;
    flush        = 1'b0;
    apply_reset();
    reset_and_idle();
    alu_ops();
    cond_branches();
    jumps();
    stall_and_flush();
    $display("Summary: %0d mismatches, %0d timeouts", mismatch_count, timeout_count);
    if (mismatch_count == 0 && timeout_count == 0) begin
      $display("Verification passed");
    end else begin
      $display("Verification failed");
    end
    $finish;
  end

endmodule

`default_nettype wire
